//--- sim.f
logic/capture_cfg_pkg.sv
logic/stream_pkg.sv
logic/capture_memory.sv
logic/write_pointer.sv
logic/readout_stage.sv
logic/capture_control.sv
logic/capture_buffer.sv
sim/capture_buffer_tb.sv

//--- Bender.yml
package:
  name: capture_buffer

sources:
  # Packages first, the beat struct depends on the sizing package
  - logic/capture_cfg_pkg.sv
  - logic/stream_pkg.sv
  # Datapath and control blocks
  - logic/capture_memory.sv
  - logic/write_pointer.sv
  - logic/readout_stage.sv
  - logic/capture_control.sv
  # Top level
  - logic/capture_buffer.sv
  # Testbench
  - target: simulation
    files:
      - sim/capture_buffer_tb.sv

//--- sim/capture_buffer_tb.sv
// Testbench for the capture buffer: LFSR stimulus, reference window model and assertion checks
module capture_buffer_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RUNS = 4;
    localparam int TIMEOUT_CYCLES = RUNS * (3 * capture_cfg_pkg::DEPTH * 4);

    logic                     clock;
    logic                     reset;
    logic                     enable;
    logic                     trigger;
    capture_cfg_pkg::addr_t   trigger_point;
    stream_pkg::stream_beat_t in_beat;
    logic                     in_valid;
    logic                     in_ready;
    stream_pkg::stream_beat_t out_beat;
    logic                     out_valid;
    logic                     out_ready;
    logic                     out_last;
    logic                     full;

    logic [31:0]              lfsr = 32'h8764;
    logic                     stall_mode = 1'b0;
    capture_cfg_pkg::data_t   beat_seq = '0;
    stream_pkg::stream_beat_t next_beat;
    int                       cycle_count = 0;

    // Reference model state
    stream_pkg::stream_beat_t accepted[$];
    stream_pkg::stream_beat_t window[capture_cfg_pkg::DEPTH];
    stream_pkg::stream_beat_t expected_beat;
    stream_pkg::stream_beat_t held_beat;
    logic                     held_last;
    logic                     stalled_before;
    logic                     model_full;
    logic                     acquiring;
    logic                     model_mark;
    logic                     last_expected;
    int                       trigger_index;
    int                       window_base;
    int                       post_target;
    int                       post_count;
    int                       out_index;
    int                       captures_done = 0;

    capture_buffer UUT (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .trigger       (trigger),
        .trigger_point (trigger_point),
        .in_beat       (in_beat),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_last      (out_last),
        .full          (full)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        logic        feedback;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], feedback};
            bits = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    task automatic report_failure(input string message);
        $display("STATUS: FAIL");
        $display("%s", message);
        $fatal(1);
    endtask

    // Input beats carry a running sequence number that advances on each accepted beat
    always @(posedge clock) begin
        if (reset) begin
            in_valid  <= 1'b0;
            out_ready <= 1'b0;
        end else begin
            if (in_valid && in_ready) begin
                beat_seq = beat_seq + 1'b1;
                next_beat.data = beat_seq;
                next_beat.dest = capture_cfg_pkg::dest_t'(take_bits(capture_cfg_pkg::DEST_W));
                next_beat.user = capture_cfg_pkg::user_t'(take_bits(capture_cfg_pkg::USER_W));
                in_beat <= next_beat;
            end
            in_valid <= (take_bits(2) != 32'd0);
            if (stall_mode) begin
                out_ready <= take_bits(1) != 32'd0;
            end else begin
                out_ready <= 1'b1;
            end
        end
    end

    // Armed or acquiring, the input simply follows enable
    ready_follows_enable: assert property (@(posedge clock) disable iff (reset)
        !full |-> (in_ready == enable))
        else report_failure($sformatf("mismatch at %0t: in_ready expected %b actual %b",
            $time, $sampled(enable), $sampled(in_ready)));

    ready_low_when_full: assert property (@(posedge clock) disable iff (reset)
        full |-> !in_ready)
        else report_failure($sformatf("mismatch at %0t: in_ready expected 0 actual %b",
            $time, $sampled(in_ready)));

    valid_only_when_full: assert property (@(posedge clock) disable iff (reset)
        !full |-> !out_valid)
        else report_failure($sformatf("mismatch at %0t: out_valid expected 0 actual %b",
            $time, $sampled(out_valid)));

    last_only_with_valid: assert property (@(posedge clock) disable iff (reset)
        out_last |-> out_valid)
        else report_failure($sformatf("mismatch at %0t: out_last expected 0 actual %b",
            $time, $sampled(out_last)));

    // Reference model and output checker, both working on the values before each edge
    always @(posedge clock) begin
        if (reset) begin
            model_full     = 1'b0;
            acquiring      = 1'b0;
            out_index      = 0;
            stalled_before = 1'b0;
        end else begin
            assert (full === model_full)
                else report_failure($sformatf("mismatch at %0t: full expected %b actual %b",
                    $time, model_full, full));

            // A stalled beat must still be there, unchanged, one cycle later
            if (stalled_before) begin
                assert (out_valid === 1'b1)
                    else report_failure($sformatf(
                        "mismatch at %0t: out_valid expected 1 actual %b", $time, out_valid));
                assert (out_beat === held_beat)
                    else report_failure($sformatf(
                        "mismatch at %0t: out_beat expected %h actual %h",
                        $time, held_beat, out_beat));
                assert (out_last === held_last)
                    else report_failure($sformatf(
                        "mismatch at %0t: out_last expected %b actual %b",
                        $time, held_last, out_last));
            end
            stalled_before = out_valid && !out_ready;
            held_beat      = out_beat;
            held_last      = out_last;

            // Decided on the state before this edge, so a trigger in the reading phase is ignored
            model_mark = trigger && enable && !model_full && !acquiring;

            if (out_valid && out_ready) begin
                expected_beat = window[out_index];
                last_expected = (out_index == capture_cfg_pkg::DEPTH - 1);
                assert (out_beat.data === expected_beat.data)
                    else report_failure($sformatf(
                        "mismatch at %0t: out_beat.data expected %h actual %h",
                        $time, expected_beat.data, out_beat.data));
                assert (out_beat.dest === expected_beat.dest)
                    else report_failure($sformatf(
                        "mismatch at %0t: out_beat.dest expected %h actual %h",
                        $time, expected_beat.dest, out_beat.dest));
                assert (out_beat.user === expected_beat.user)
                    else report_failure($sformatf(
                        "mismatch at %0t: out_beat.user expected %h actual %h",
                        $time, expected_beat.user, out_beat.user));
                assert (out_last === last_expected)
                    else report_failure($sformatf(
                        "mismatch at %0t: out_last expected %b actual %b",
                        $time, last_expected, out_last));
                out_index = out_index + 1;
                if (out_index == capture_cfg_pkg::DEPTH) begin
                    out_index     = 0;
                    model_full    = 1'b0;
                    captures_done = captures_done + 1;
                end
            end

            // The next accepted beat takes the slot that is current at the trigger
            if (model_mark) begin
                trigger_index = accepted.size();
                window_base   = trigger_index - int'(trigger_point);
                post_target   = capture_cfg_pkg::DEPTH - int'(trigger_point);
                post_count    = 0;
                acquiring     = 1'b1;
            end

            if (in_valid && in_ready) begin
                accepted.push_back(in_beat);
                if (acquiring) begin
                    post_count = post_count + 1;
                    if (post_count == post_target) begin
                        acquiring  = 1'b0;
                        model_full = 1'b1;
                        for (int k = 0; k < capture_cfg_pkg::DEPTH; k++) begin
                            window[k] = accepted[window_base + k];
                        end
                    end
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout: the run did not finish within %0d cycles",
                TIMEOUT_CYCLES));
        end
    end

    // One capture: fill the ring, trigger, then wait until the whole window has been replayed
    task automatic run_capture(input int point, input logic stalls);
        int start_count;
        int done_before;
        @(posedge clock);
        trigger_point <= capture_cfg_pkg::addr_t'(point);
        stall_mode    <= stalls;
        @(negedge clock);
        start_count = accepted.size();
        done_before = captures_done;
        while (accepted.size() < start_count + capture_cfg_pkg::DEPTH) begin
            @(negedge clock);
        end
        @(posedge clock);
        trigger <= 1'b1;
        @(posedge clock);
        trigger <= 1'b0;
        do begin
            @(negedge clock);
        end while (!full);
        // A second trigger during the readout has no effect
        @(posedge clock);
        trigger <= 1'b1;
        @(posedge clock);
        trigger <= 1'b0;
        do begin
            @(negedge clock);
        end while (captures_done == done_before);
    endtask

    initial begin
        reset         = 1'b1;
        enable        = 1'b0;
        trigger       = 1'b0;
        trigger_point = '0;
        in_beat       = '0;
        in_valid      = 1'b0;
        out_ready     = 1'b0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;

        // A trigger while disabled must not start a capture
        repeat (2) @(posedge clock);
        trigger <= 1'b1;
        @(posedge clock);
        trigger <= 1'b0;
        repeat (4) @(posedge clock);
        enable <= 1'b1;

        run_capture(0, 1'b0);
        run_capture(17, 1'b1);
        run_capture(capture_cfg_pkg::DEPTH - 1, 1'b1);
        run_capture(0, 1'b1);

        @(negedge clock);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- logic/capture_buffer.sv
// Triggered capture buffer top: control FSM plus write, memory and readout datapath
module capture_buffer (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     enable,
    input  logic                     trigger,
    input  capture_cfg_pkg::addr_t   trigger_point,
    input  stream_pkg::stream_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output stream_pkg::stream_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic                     out_last,
    output logic                     full
);

    logic                     write_open;
    logic                     mark;
    logic                     beat_written;
    logic                     start_readout;
    logic                     readout_done;
    logic                     wr_en;
    capture_cfg_pkg::addr_t   wr_addr;
    stream_pkg::stream_beat_t wr_beat;
    capture_cfg_pkg::addr_t   window_start;
    logic                     rd_en;
    capture_cfg_pkg::addr_t   rd_addr;
    stream_pkg::stream_beat_t rd_beat;

    assign in_ready = write_open;

    capture_control control (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .trigger       (trigger),
        .trigger_point (trigger_point),
        .beat_written  (beat_written),
        .readout_done  (readout_done),
        .write_open    (write_open),
        .mark          (mark),
        .start_readout (start_readout),
        .full          (full)
    );

    write_pointer writer (
        .clock         (clock),
        .reset         (reset),
        .write_open    (write_open),
        .mark          (mark),
        .trigger_point (trigger_point),
        .in_beat       (in_beat),
        .in_valid      (in_valid),
        .beat_written  (beat_written),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_beat       (wr_beat),
        .window_start  (window_start)
    );

    capture_memory memory (
        .clock   (clock),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_beat (wr_beat),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_beat (rd_beat)
    );

    readout_stage reader (
        .clock         (clock),
        .reset         (reset),
        .start_readout (start_readout),
        .window_start  (window_start),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_beat       (rd_beat),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_last      (out_last),
        .readout_done  (readout_done)
    );

endmodule

//--- logic/capture_control.sv
// Capture FSM: arms the input, counts post-trigger beats, declares full and runs the readout
module capture_control (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   enable,
    input  logic                   trigger,
    input  capture_cfg_pkg::addr_t trigger_point,
    input  logic                   beat_written,
    input  logic                   readout_done,
    output logic                   write_open,
    output logic                   mark,
    output logic                   start_readout,
    output logic                   full
);

    typedef enum logic [1:0] {
        state_armed,
        state_acquiring,
        state_reading
    } state_t;

    state_t                  state;
    capture_cfg_pkg::count_t post_target;
    capture_cfg_pkg::count_t post_count;
    capture_cfg_pkg::count_t target_now;
    capture_cfg_pkg::count_t count_next;

    // Beats still to be taken from the trigger onwards, from 1 up to DEPTH
    assign target_now = capture_cfg_pkg::count_t'(capture_cfg_pkg::DEPTH)
                      - capture_cfg_pkg::count_t'(trigger_point);

    // A trigger only counts while armed and enabled
    assign mark = trigger && enable && (state == state_armed);

    // The input follows enable until the window is frozen
    assign write_open = enable & ~full;

    // The trigger cycle starts a fresh count and includes its own beat
    always_comb begin
        if (state == state_armed) begin
            count_next = capture_cfg_pkg::count_t'(beat_written);
        end else begin
            count_next = post_count + capture_cfg_pkg::count_t'(beat_written);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state         <= state_armed;
            post_count    <= '0;
            post_target   <= '0;
            start_readout <= 1'b0;
            full          <= 1'b0;
        end else begin
            start_readout <= 1'b0;
            case (state)
                state_armed: begin
                    if (mark) begin
                        post_target <= target_now;
                        post_count  <= count_next;
                        // With trigger_point at DEPTH-1 the trigger beat alone ends the window
                        if (count_next == target_now) begin
                            state         <= state_reading;
                            full          <= 1'b1;
                            start_readout <= 1'b1;
                        end else begin
                            state <= state_acquiring;
                        end
                    end
                end
                state_acquiring: begin
                    post_count <= count_next;
                    if (count_next == post_target) begin
                        state         <= state_reading;
                        full          <= 1'b1;
                        start_readout <= 1'b1;
                    end
                end
                state_reading: begin
                    if (readout_done) begin
                        state <= state_armed;
                        full  <= 1'b0;
                    end
                end
                default: begin
                    state <= state_armed;
                end
            endcase
        end
    end

endmodule

//--- logic/readout_stage.sv
// Replays a captured window from memory onto the output stream through a two-entry skid buffer
module readout_stage (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     start_readout,
    input  capture_cfg_pkg::addr_t   window_start,
    output logic                     rd_en,
    output capture_cfg_pkg::addr_t   rd_addr,
    input  stream_pkg::stream_beat_t rd_beat,
    output stream_pkg::stream_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic                     out_last,
    output logic                     readout_done
);

    // A buffered beat together with its end of window flag
    typedef struct packed {
        stream_pkg::stream_beat_t beat;
        logic                     last;
    } skid_entry_t;

    capture_cfg_pkg::addr_t  rd_ptr;
    capture_cfg_pkg::count_t reads_left;
    logic                    in_flight;
    logic                    in_flight_last;
    logic [1:0]              occupancy;
    logic [1:0]              committed;
    logic                    push;
    logic                    pop;
    skid_entry_t             head;
    skid_entry_t             tail;
    skid_entry_t             incoming;

    assign pop  = out_valid & out_ready;
    assign push = in_flight;

    // Entries that will be taken once this cycle settles, counting the read
    // already in the memory pipeline and the beat leaving now
    assign committed = occupancy + {1'b0, in_flight} - {1'b0, pop};

    // Only issue a read when its beat is sure to find a free entry
    assign rd_en   = (reads_left != '0) && (committed < 2'd2);
    assign rd_addr = rd_ptr;

    // The memory answers one cycle after the read
    assign incoming.beat = rd_beat;
    assign incoming.last = in_flight_last;

    always_ff @(posedge clock) begin
        if (reset) begin
            reads_left     <= '0;
            in_flight      <= 1'b0;
            in_flight_last <= 1'b0;
            occupancy      <= '0;
        end else begin
            in_flight      <= rd_en;
            in_flight_last <= rd_en && (reads_left == capture_cfg_pkg::count_t'(1));
            if (start_readout) begin
                reads_left <= capture_cfg_pkg::count_t'(capture_cfg_pkg::DEPTH);
            end else if (rd_en) begin
                reads_left <= reads_left - 1'b1;
            end
            occupancy <= occupancy + {1'b0, push} - {1'b0, pop};
        end
    end

    // The read address wraps with the ring, just like the write address
    always_ff @(posedge clock) begin
        if (start_readout) begin
            rd_ptr <= window_start;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Head drives the output. It only changes on a pop or when it is empty,
    // which keeps the output stable under back-pressure
    always_ff @(posedge clock) begin
        case ({push, pop})
            2'b10: begin
                if (occupancy == 2'd0) begin
                    head <= incoming;
                end else begin
                    tail <= incoming;
                end
            end
            2'b01: begin
                head <= tail;
            end
            2'b11: begin
                if (occupancy == 2'd1) begin
                    head <= incoming;
                end else begin
                    head <= tail;
                    tail <= incoming;
                end
            end
            default: begin
            end
        endcase
    end

    assign out_valid = (occupancy != 2'd0);
    assign out_beat  = head.beat;
    assign out_last  = out_valid & head.last;

    // The window is over once its flagged beat has been taken
    assign readout_done = pop & head.last;

endmodule

//--- logic/write_pointer.sv
// Input side of the capture ring: accepts beats, advances the write address, marks the window
module write_pointer (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     write_open,
    input  logic                     mark,
    input  capture_cfg_pkg::addr_t   trigger_point,
    input  stream_pkg::stream_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     beat_written,
    output logic                     wr_en,
    output capture_cfg_pkg::addr_t   wr_addr,
    output stream_pkg::stream_beat_t wr_beat,
    output capture_cfg_pkg::addr_t   window_start
);

    capture_cfg_pkg::addr_t write_addr;
    logic                   accept;

    // A beat transfers whenever the input is open and offers data
    assign accept = in_valid & write_open;

    // The write lands on the same edge as the transfer
    assign wr_en   = accept;
    assign wr_addr = write_addr;
    assign wr_beat = in_beat;

    // Control counts this pulse in the same cycle
    assign beat_written = accept;

    // The ring keeps running across captures and only restarts on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            write_addr <= '0;
        end else if (accept) begin
            write_addr <= write_addr + 1'b1;
        end
    end

    // The beat taken in the trigger cycle lands at write_addr, so the window
    // begins trigger_point slots before it (wrapping around the ring)
    always_ff @(posedge clock) begin
        if (mark) begin
            window_start <= write_addr - trigger_point;
        end
    end

endmodule

//--- logic/capture_memory.sv
// Simple dual-port beat memory with one write port and a registered read port
module capture_memory (
    input  logic                     clock,
    input  logic                     wr_en,
    input  capture_cfg_pkg::addr_t   wr_addr,
    input  stream_pkg::stream_beat_t wr_beat,
    input  logic                     rd_en,
    input  capture_cfg_pkg::addr_t   rd_addr,
    output stream_pkg::stream_beat_t rd_beat
);

    // Plain array with separate write and read processes so it maps onto block RAM
    stream_pkg::stream_beat_t mem [capture_cfg_pkg::DEPTH];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // The output register only loads on a read, so the last beat read stays
    // available while the consumer is stalled
    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_beat <= mem[rd_addr];
        end
    end

endmodule

//--- logic/stream_pkg.sv
// Stream beat layout shared by the input stream, the capture memory and the output stream
package stream_pkg;

    // One beat as it is written to memory and replayed, 48 bits in all.
    // The handshake bits and last travel beside it and are not stored.
    typedef struct packed {
        capture_cfg_pkg::data_t data;
        capture_cfg_pkg::dest_t dest;
        capture_cfg_pkg::user_t user;
    } stream_beat_t;

endpackage

//--- logic/capture_cfg_pkg.sv
// Capture buffer sizing: memory depth, beat field widths and the vector types built from them
package capture_cfg_pkg;

    // Address width of the capture memory, which also sets the window length
    localparam int ADDR_W = 6;

    // One capture window fills the whole memory
    localparam int DEPTH = 1 << ADDR_W;

    // Field widths of one stream beat
    localparam int DATA_W = 32;
    localparam int DEST_W = 8;
    localparam int USER_W = 8;

    // Memory address and trigger position, wrapping modulo DEPTH
    typedef logic [ADDR_W-1:0] addr_t;

    // One extra bit so that a count can reach DEPTH itself
    typedef logic [ADDR_W:0] count_t;

    // Payload fields of a beat
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [DEST_W-1:0] dest_t;
    typedef logic [USER_W-1:0] user_t;

endpackage
